/* src/sprite_macros.svh */
`ifndef SPRITE_MACROS_SVH
`define SPRITE_MACROS_SVH

// line geometry
`define LINE_PIXELS   64
`define POS_W         6
`define LINE_W        8
`define COLOR_W       8

// descriptor table and its fields
`define SPRITE_COUNT  8
`define IDX_W         3
`define SPR_X_W       7   // one spare bit so a sprite can start past the line
`define SPR_H_W       8
`define SPR_WW_W      4
`define SPR_PAL_W     6

// external memory
`define MEM_ADDR_W    16
`define MEM_WORD_W    16

`endif

/* src/video_pkg.sv */
`include "sprite_macros.svh"

package video_pkg;

	// ------------------------------------------------------------------------
	// plain widths
	// ------------------------------------------------------------------------

	typedef logic [`LINE_W-1:0]  line_num_t;   // line number in the frame
	typedef logic [`POS_W-1:0]   pix_pos_t;    // pixel position in a line
	typedef logic [`COLOR_W-1:0] color_t;      // palette color sent to the display

	// ------------------------------------------------------------------------
	// line buffer entries
	// ------------------------------------------------------------------------

	// one stored pixel, opaque clear means nothing drawn here
	typedef struct packed {
		logic   opaque;
		color_t color;
	} buf_pixel_t;

	// pixel write from the fetcher, qualified by wr_strobe
	typedef struct packed {
		pix_pos_t   pos;
		buf_pixel_t pixel;
	} buf_write_t;

endpackage

/* src/sprite_pkg.sv */
`include "sprite_macros.svh"

package sprite_pkg;

	// ------------------------------------------------------------------------
	// memory and table
	// ------------------------------------------------------------------------

	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;    // word address
	typedef logic [`MEM_WORD_W-1:0] mem_word_t;    // one packed word of pixels
	typedef logic [`IDX_W-1:0]      sprite_idx_t;  // descriptor number

	// bits per pixel of a sprite
	typedef enum logic [1:0] {
		cm_off = 2'd0,  // sprite disabled
		cm_4c  = 2'd1,  // 2 bpp, 8 px per word
		cm_16c = 2'd2   // 4 bpp, 4 px per word
	} color_mode_e;

	// one entry of the descriptor table, mode on top
	typedef struct packed {
		color_mode_e           mode;
		logic                  flip_x;
		logic [`SPR_X_W-1:0]   x;            // left edge, may lie past the line
		video_pkg::line_num_t  y;            // first line covered
		logic [`SPR_H_W-1:0]   height;       // lines covered
		logic [`SPR_WW_W-1:0]  width_words;  // words per sprite row
		logic [`SPR_PAL_W-1:0] pal;          // upper color bits
		mem_addr_t             base;         // address of row 0, word 0
	} sprite_desc_t;

	// fetcher FSM
	typedef enum logic [2:0] {
		st_idle,   // line done or drawing off
		st_desc,   // table address out
		st_check,  // table data in, mode and row test
		st_addr,   // first word address, request
		st_wait,   // waiting for the memory reply
		st_emit    // one pixel per cycle to the buffer
	} fetch_state_e;

endpackage

/* src/sprite_fetch.sv */
`timescale 1ns/10ps
`include "sprite_macros.svh"

module sprite_fetch
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     enable,
	input  logic                     frame_start,
	input  logic                     line_start,
	output sprite_pkg::sprite_idx_t  desc_addr,
	input  sprite_pkg::sprite_desc_t desc_data,
	output logic                     mem_req,
	output sprite_pkg::mem_addr_t    mem_addr,
	input  logic                     mem_valid,
	input  sprite_pkg::mem_word_t    mem_data,
	output logic                     wr_strobe,
	output video_pkg::buf_write_t    wr
);

	sprite_pkg::fetch_state_e state_q;
	video_pkg::line_num_t     line_q;     // line being drawn
	sprite_pkg::sprite_idx_t  idx_q;      // current descriptor
	sprite_pkg::sprite_desc_t desc_q;     // latched descriptor
	video_pkg::line_num_t     row_q;      // line - y
	logic [`SPR_WW_W-1:0]     word_q;     // word in sprite row
	logic [2:0]               cnt_q;      // pixel in word
	logic [7:0]               pos_q;      // line position that can run past the end
	sprite_pkg::mem_word_t    shift_q;    // word being unpacked msb first
	logic                     pend_q;     // request out and reply not back yet

	logic [8:0]               row_diff;
	logic                     row_hit;
	logic                     spr_hit;
	logic                     is_16c;
	logic                     last_pix;
	logic                     last_word;
	logic                     last_spr;
	logic                     on_line;
	logic [3:0]               pix_idx;
	logic [6:0]               span;       // sprite width in pixels
	video_pkg::color_t        pix_color;

	// ------------------------------------------------------------------------
	// descriptor test valid in st_check
	// ------------------------------------------------------------------------

	assign desc_addr = idx_q;
	assign row_diff  = {1'b0, line_q} - {1'b0, desc_data.y};  // borrow => above the sprite
	assign row_hit   = !row_diff[8] && (row_diff[7:0] < desc_data.height);
	assign spr_hit   = (desc_data.mode == sprite_pkg::cm_4c ||
		desc_data.mode == sprite_pkg::cm_16c) &&
		(desc_data.width_words != '0) && row_hit;
	assign last_spr  = idx_q == sprite_pkg::sprite_idx_t'(`SPRITE_COUNT - 1);

	// ------------------------------------------------------------------------
	// unpacking of the current word
	// ------------------------------------------------------------------------

	assign is_16c    = desc_q.mode == sprite_pkg::cm_16c;
	assign pix_idx   = is_16c ? shift_q[15:12] : {2'b00, shift_q[15:14]};
	// 16c index covers the two low palette bits
	assign pix_color = is_16c ? {desc_q.pal[5:2], shift_q[15:12]} :
		{desc_q.pal, shift_q[15:14]};
	assign last_pix  = is_16c ? (cnt_q == 3'd3) : (cnt_q == 3'd7);
	assign last_word = word_q == desc_q.width_words - 4'd1;
	assign span      = is_16c ? {1'b0, desc_q.width_words, 2'b00} :
		{desc_q.width_words, 3'b000};
	assign on_line   = pos_q < 8'(`LINE_PIXELS);  // clip right edge

	// ------------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q   <= sprite_pkg::st_idle;
			line_q    <= '0;
			idx_q     <= '0;
			word_q    <= '0;
			cnt_q     <= '0;
			pend_q    <= 1'b0;
			mem_req   <= 1'b0;
			wr_strobe <= 1'b0;
		end
		else
		begin
			mem_req   <= 1'b0;  // single cycle strobes
			wr_strobe <= 1'b0;

			if (frame_start)
				line_q <= '0;
			else if (line_start)
				line_q <= line_q + 1'b1;

			// a reply to an aborted line still has to drain
			if (mem_req)
				pend_q <= 1'b1;
			else if (mem_valid)
				pend_q <= 1'b0;

			if (line_start)
			begin
				idx_q   <= '0;  // restart the table and drop the rest
				state_q <= enable ? sprite_pkg::st_desc : sprite_pkg::st_idle;
			end
			else
			begin
				case (state_q)
				sprite_pkg::st_desc:
					state_q <= sprite_pkg::st_check;
				sprite_pkg::st_check:
				begin
					if (spr_hit)
						state_q <= sprite_pkg::st_addr;
					else if (last_spr)
						state_q <= sprite_pkg::st_idle;
					else
					begin
						idx_q   <= idx_q + 1'b1;  // skip when off or not on this line
						state_q <= sprite_pkg::st_desc;
					end
				end
				sprite_pkg::st_addr:
				begin
					if (!pend_q)
					begin
						mem_req <= 1'b1;
						word_q  <= '0;
						state_q <= sprite_pkg::st_wait;
					end
				end
				sprite_pkg::st_wait:
				begin
					if (mem_valid)
					begin
						cnt_q   <= '0;
						state_q <= sprite_pkg::st_emit;
					end
				end
				sprite_pkg::st_emit:
				begin
					wr_strobe <= (pix_idx != 4'd0) && on_line;  // index 0 transparent
					cnt_q     <= cnt_q + 1'b1;
					if (last_pix)
					begin
						if (!last_word)
						begin
							mem_req <= 1'b1;  // next word of this row
							word_q  <= word_q + 1'b1;
							state_q <= sprite_pkg::st_wait;
						end
						else if (last_spr)
							state_q <= sprite_pkg::st_idle;
						else
						begin
							idx_q   <= idx_q + 1'b1;
							state_q <= sprite_pkg::st_desc;
						end
					end
				end
				default:
					state_q <= sprite_pkg::st_idle;
				endcase
			end
		end
	end

	// ------------------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		case (state_q)
		sprite_pkg::st_check:
		begin
			desc_q <= desc_data;
			row_q  <= row_diff[7:0];
		end
		sprite_pkg::st_addr:
		begin
			// base + row * width_words
			mem_addr <= desc_q.base + sprite_pkg::mem_addr_t'(row_q) *
				sprite_pkg::mem_addr_t'(desc_q.width_words);
			// flipped sprites are drawn from their right edge leftwards
			pos_q <= desc_q.flip_x ? {1'b0, desc_q.x} + {1'b0, span} - 8'd1 :
				{1'b0, desc_q.x};
		end
		sprite_pkg::st_wait:
			if (mem_valid)
				shift_q <= mem_data;
		sprite_pkg::st_emit:
		begin
			shift_q <= is_16c ? shift_q << 4 : shift_q << 2;
			pos_q   <= desc_q.flip_x ? pos_q - 8'd1 : pos_q + 8'd1;
			wr.pos  <= video_pkg::pix_pos_t'(pos_q);
			wr.pixel.opaque <= 1'b1;
			wr.pixel.color  <= pix_color;
			if (last_pix)
				mem_addr <= mem_addr + 1'b1;  // words of a row are adjacent
		end
		default: ;
		endcase
	end

endmodule

/* src/line_buffer.sv */
`timescale 1ns/10ps
`include "sprite_macros.svh"

module line_buffer
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  line_start,
	input  logic                  wr_strobe,
	input  video_pkg::buf_write_t wr,
	input  video_pkg::pix_pos_t   rd_pos,
	input  logic                  rd_clear,
	output video_pkg::buf_pixel_t rd_pixel
);

	// ------------------------------------------------------------------------
	// storage
	// ------------------------------------------------------------------------

	video_pkg::buf_pixel_t bank [2][`LINE_PIXELS];  // two line images

	logic sel_q;  // front bank, the one being shown
	logic back;   // bank being drawn

	assign back = ~sel_q;

	// read side, combinational from the front bank
	assign rd_pixel = bank[sel_q][rd_pos];

	// ------------------------------------------------------------------------
	// bank select
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			sel_q <= 1'b0;
		else if (line_start)
			sel_q <= ~sel_q;  // drawn line goes on screen
	end

	// ------------------------------------------------------------------------
	// writes and clears
	// ------------------------------------------------------------------------

	// draw into the back bank, later writes win
	// scan-out wipes each front location it has read, so the bank
	// comes back blank when it turns into the back bank again
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int b = 0; b < 2; b++)
			begin
				for (int i = 0; i < `LINE_PIXELS; i++)
				begin
					bank[b][i] <= '0;
				end
			end
		end
		else
		begin
			if (wr_strobe)
				bank[back][wr.pos] <= wr.pixel;
			if (rd_clear)
				bank[sel_q][rd_pos] <= '0;  // other bank, never collides
		end
	end

endmodule

/* src/line_scanout.sv */
`timescale 1ns/10ps
`include "sprite_macros.svh"

module line_scanout
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  line_start,
	input  logic                  pix_strobe,
	output video_pkg::pix_pos_t   rd_pos,
	output logic                  rd_clear,
	input  video_pkg::buf_pixel_t rd_pixel,
	output video_pkg::color_t     pixel,
	output logic                  pix_valid
);

	video_pkg::pix_pos_t pos_q;   // next pixel to show
	logic                at_end;  // last pixel of the line

	assign at_end   = pos_q == video_pkg::pix_pos_t'(`LINE_PIXELS - 1);
	assign rd_pos   = pos_q;
	assign rd_clear = pix_strobe;  // wipe what is read this cycle

	// ------------------------------------------------------------------------
	// position and valid
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pos_q     <= '0;
			pix_valid <= 1'b0;
		end
		else
		begin
			pix_valid <= pix_strobe;  // one cycle after the strobe
			if (line_start)
				pos_q <= '0;
			else if (pix_strobe && !at_end)
				pos_q <= pos_q + 1'b1;  // holds on the last pixel
		end
	end

	// transparent shows as color 0
	always_ff @(posedge clk)
	begin
		if (pix_strobe)
			pixel <= rd_pixel.opaque ? rd_pixel.color : '0;
	end

endmodule

/* src/sprite_engine.sv */
`timescale 1ns/10ps

module sprite_engine
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     enable,
	input  logic                     frame_start,
	input  logic                     line_start,
	input  logic                     pix_strobe,
	output sprite_pkg::sprite_idx_t  desc_addr,
	input  sprite_pkg::sprite_desc_t desc_data,
	output logic                     mem_req,
	output sprite_pkg::mem_addr_t    mem_addr,
	input  logic                     mem_valid,
	input  sprite_pkg::mem_word_t    mem_data,
	output video_pkg::color_t        pixel,
	output logic                     pix_valid
);

	// fetcher to buffer
	logic                  wr_strobe;
	video_pkg::buf_write_t wr;

	// scan-out to buffer
	video_pkg::pix_pos_t   rd_pos;
	logic                  rd_clear;
	video_pkg::buf_pixel_t rd_pixel;

	// ------------------------------------------------------------------------
	// producer, buffer, consumer
	// ------------------------------------------------------------------------

	sprite_fetch u_fetch
	(
		.clk         (clk),
		.arst_n      (arst_n),
		.enable      (enable),
		.frame_start (frame_start),
		.line_start  (line_start),
		.desc_addr   (desc_addr),
		.desc_data   (desc_data),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_valid   (mem_valid),
		.mem_data    (mem_data),
		.wr_strobe   (wr_strobe),
		.wr          (wr)
	);

	line_buffer u_buffer
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.line_start (line_start),
		.wr_strobe  (wr_strobe),
		.wr         (wr),
		.rd_pos     (rd_pos),
		.rd_clear   (rd_clear),
		.rd_pixel   (rd_pixel)
	);

	line_scanout u_scanout
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.line_start (line_start),
		.pix_strobe (pix_strobe),
		.rd_pos     (rd_pos),
		.rd_clear   (rd_clear),
		.rd_pixel   (rd_pixel),
		.pixel      (pixel),
		.pix_valid  (pix_valid)
	);

endmodule

/* testbench/sprite_engine_tb.sv */
`timescale 1ns/10ps
`include "sprite_macros.svh"

module sprite_engine_tb;

	localparam int NUM_TESTS = 6;
	localparam int PERIOD    = 400;  // cycles per line
	localparam int DRAW_WAIT = 200;  // line_start to first pix_strobe

	logic                     clk;
	logic                     arst_n;
	logic                     enable;
	logic                     frame_start;
	logic                     line_start;
	logic                     pix_strobe;
	sprite_pkg::sprite_idx_t  desc_addr;
	sprite_pkg::sprite_desc_t desc_data;
	logic                     mem_req;
	sprite_pkg::mem_addr_t    mem_addr;
	logic                     mem_valid;
	sprite_pkg::mem_word_t    mem_data;
	video_pkg::color_t        pixel;
	logic                     pix_valid;

	sprite_pkg::mem_word_t    mem [65536];                         // sprite pixel words
	sprite_pkg::sprite_desc_t cur_desc [`SPRITE_COUNT];           // table seen by the DUT
	sprite_pkg::sprite_desc_t tbl_desc [NUM_TESTS][`SPRITE_COUNT];
	int                       tbl_lines [NUM_TESTS];              // lines shown per test
	logic                     tbl_en [NUM_TESTS];
	logic [31:0]              seed;
	sprite_pkg::sprite_idx_t  desc_addr_q;
	sprite_pkg::mem_addr_t    req_addr;
	int                       req_cnt;                            // cycles to the reply
	int                       pass_count;
	int                       fail_count;
	int                       bus_errs;                           // memory handshake faults

	sprite_engine dut
	(
		.clk         (clk),
		.arst_n      (arst_n),
		.enable      (enable),
		.frame_start (frame_start),
		.line_start  (line_start),
		.pix_strobe  (pix_strobe),
		.desc_addr   (desc_addr),
		.desc_data   (desc_data),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_valid   (mem_valid),
		.mem_data    (mem_data),
		.pixel       (pixel),
		.pix_valid   (pix_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [15:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[30:15];
	endfunction

	function automatic sprite_pkg::sprite_desc_t make_desc(sprite_pkg::color_mode_e mode,
		logic flip, logic [`SPR_X_W-1:0] x, video_pkg::line_num_t y,
		logic [`SPR_H_W-1:0] height, logic [`SPR_WW_W-1:0] ww,
		logic [`SPR_PAL_W-1:0] pal, sprite_pkg::mem_addr_t base);
		sprite_pkg::sprite_desc_t d;
		d.mode        = mode;
		d.flip_x      = flip;
		d.x           = x;
		d.y           = y;
		d.height      = height;
		d.width_words = ww;
		d.pal         = pal;
		d.base        = base;
		return d;
	endfunction

	// expected color at one position in table order so later sprites win
	function automatic video_pkg::color_t expect_pixel(int line, int pos, logic en);
		sprite_pkg::sprite_desc_t d;
		video_pkg::color_t        c;
		sprite_pkg::mem_word_t    w;
		int                       bpp;
		int                       ppw;
		int                       span;
		int                       row;
		int                       j;
		int                       idx;
		c = '0;
		if (!en)
			return c;
		for (int s = 0; s < `SPRITE_COUNT; s++)
		begin
			d = cur_desc[s];
			if (d.mode != sprite_pkg::cm_4c && d.mode != sprite_pkg::cm_16c)
				continue;
			bpp  = (d.mode == sprite_pkg::cm_16c) ? 4 : 2;
			ppw  = 16 / bpp;
			span = int'(d.width_words) * ppw;
			row  = line - int'(d.y);
			if (row < 0 || row >= int'(d.height) || span == 0)
				continue;
			// sprite pixel that lands here
			j = d.flip_x ? int'(d.x) + span - 1 - pos : pos - int'(d.x);
			if (j < 0 || j >= span)
				continue;
			w   = mem[16'(int'(d.base) + row * int'(d.width_words) + j / ppw)];
			idx = (int'(w) >> (16 - bpp * (j % ppw + 1))) & ((1 << bpp) - 1);
			if (idx == 0)
				continue;  // transparent so keep what is below
			c = (bpp == 4) ? {d.pal[5:2], 4'(idx)} : {d.pal, 2'(idx)};
		end
		return c;
	endfunction

	// ------------------------------------------------------------------------
	// descriptor table and memory models
	// ------------------------------------------------------------------------

	initial
	begin
		forever
		begin
			@(posedge clk);
			#1;
			desc_data   = cur_desc[desc_addr_q];  // address of the cycle before
			desc_addr_q = desc_addr;
		end
	end

	initial
	begin : mem_model
		logic busy;  // a reply is still owed to the DUT
		forever
		begin
			@(posedge clk);
			#1;
			busy      = req_cnt > 0;
			mem_valid = 1'b0;
			if (req_cnt > 0)
			begin
				req_cnt--;
				if (req_cnt == 0)
				begin
					mem_valid = 1'b1;
					mem_data  = mem[req_addr];
				end
			end
			if (mem_req)
			begin
				if (busy)
				begin
					$display("memory request at %0t before the previous reply came back",
						$time);
					bus_errs++;
				end
				req_addr = mem_addr;
				req_cnt  = int'(lcg_next() % 16'd4) + 1;  // 1 to 4 cycles
			end
		end
	end

	// watchdog sized from every test line plus a margin
	initial
	begin : watchdog
		int periods;
		periods = 0;
		#1;
		for (int t = 0; t < NUM_TESTS; t++)
			periods += tbl_lines[t] + 1;
		#((periods * PERIOD + 100) * 10);
		$display("Timeout: the tests did not finish in time");
		$display("Verification failed");
		$finish;
	end

	// ------------------------------------------------------------------------
	// test table
	// ------------------------------------------------------------------------

	task automatic load_tests();
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			tbl_en[t] = 1'b1;
			for (int s = 0; s < `SPRITE_COUNT; s++)
				tbl_desc[t][s] = '0;  // mode off
		end
		// single 4-color sprite of 2 words
		tbl_desc[0][0] = make_desc(sprite_pkg::cm_4c, 1'b0, 7'd10, 8'd2, 8'd3, 4'd2,
			6'h15, 16'h0100);
		tbl_lines[0] = 6;
		// 16-color sprite with rows past 0
		tbl_desc[1][3] = make_desc(sprite_pkg::cm_16c, 1'b0, 7'd20, 8'd1, 8'd4, 4'd3,
			6'h2c, 16'h0400);
		tbl_lines[1] = 5;
		// flipped in both modes
		tbl_desc[2][0] = make_desc(sprite_pkg::cm_4c, 1'b1, 7'd5, 8'd0, 8'd2, 4'd2,
			6'h0a, 16'h1000);
		tbl_desc[2][1] = make_desc(sprite_pkg::cm_16c, 1'b1, 7'd40, 8'd1, 8'd2, 4'd1,
			6'h33, 16'h1100);
		tbl_lines[2] = 3;
		// overlap with a clipped right edge and one sprite off the line
		tbl_desc[3][2] = make_desc(sprite_pkg::cm_4c, 1'b0, 7'd8, 8'd0, 8'd4, 4'd2,
			6'h01, 16'h2000);
		tbl_desc[3][5] = make_desc(sprite_pkg::cm_16c, 1'b0, 7'd12, 8'd1, 8'd3, 4'd2,
			6'h3f, 16'h2100);
		tbl_desc[3][6] = make_desc(sprite_pkg::cm_4c, 1'b1, 7'd50, 8'd0, 8'd4, 4'd3,
			6'h12, 16'h2200);
		tbl_desc[3][7] = make_desc(sprite_pkg::cm_16c, 1'b0, 7'd100, 8'd0, 8'd4, 4'd1,
			6'h20, 16'h2300);
		tbl_lines[3] = 4;
		tbl_lines[4] = 3;  // empty table right after the overlap test
		for (int s = 0; s < `SPRITE_COUNT; s++)
			tbl_desc[5][s] = tbl_desc[3][s];
		tbl_en[5]    = 1'b0;  // drawing off
		tbl_lines[5] = 3;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// period 0 draws line 0 and shows unchecked leftovers
	task automatic run_test(input int t);
		video_pkg::color_t exp;
		int                errs;
		int                checked;
		errs    = 0;
		checked = 0;
		for (int s = 0; s < `SPRITE_COUNT; s++)
			cur_desc[s] = tbl_desc[t][s];
		for (int p = 0; p <= tbl_lines[t]; p++)
		begin
			enable      = tbl_en[t];
			frame_start = (p == 0);
			line_start  = 1'b1;
			next_cycle();
			frame_start = 1'b0;
			line_start  = 1'b0;
			repeat (DRAW_WAIT - 1) next_cycle();
			for (int pos = 0; pos < `LINE_PIXELS; pos++)
			begin
				pix_strobe = 1'b1;
				next_cycle();
				pix_strobe = 1'b0;
				if (p > 0)
				begin
					exp = expect_pixel(p - 1, pos, tbl_en[t]);
					checked++;
					if (!pix_valid)
					begin
						$display("test %0d line %0d pixel %0d: pix_valid missing",
							t, p - 1, pos);
						errs++;
					end
					else if (pixel !== exp)
					begin
						$display("Mismatch at %0t: test %0d line %0d px %0d got %02h exp %02h",
							$time, t, p - 1, pos, pixel, exp);
						errs++;
					end
				end
				next_cycle();
			end
			repeat (PERIOD - DRAW_WAIT - 2 * `LINE_PIXELS) next_cycle();
		end
		if (errs == 0)
			pass_count++;
		else
			fail_count++;
		$display("test %0d: %0d lines, %0d pixels checked, %0d errors",
			t, tbl_lines[t], checked, errs);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial
	begin
		arst_n      = 1'b0;
		enable      = 1'b0;
		frame_start = 1'b0;
		line_start  = 1'b0;
		pix_strobe  = 1'b0;
		desc_data   = '0;
		mem_valid   = 1'b0;
		mem_data    = '0;
		desc_addr_q = '0;
		req_addr    = '0;
		req_cnt     = 0;
		pass_count  = 0;
		fail_count  = 0;
		bus_errs    = 0;
		seed        = 32'hc997;
		for (int a = 0; a < 65536; a++)
			mem[a] = lcg_next() ^ 16'(a);
		load_tests();
		for (int s = 0; s < `SPRITE_COUNT; s++)
			cur_desc[s] = '0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		next_cycle();
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("tests passed %0d, tests failed %0d, bus errors %0d",
			pass_count, fail_count, bus_errs);
		if (fail_count == 0 && bus_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+src
src/video_pkg.sv
src/sprite_pkg.sv
src/sprite_fetch.sv
src/line_buffer.sv
src/line_scanout.sv
src/sprite_engine.sv
testbench/sprite_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sprite engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module sprite_engine_tb \
	-f flist.f -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
